//--- hdl/organ_pkg.sv
package organ_pkg;

  // ========================================
  // Tone
  // ========================================

  // 0 = Do ... 7 = high Do
  typedef logic [2:0] note_t;

  localparam int HALF_PERIOD_W = 16;

  // CLK_50M cycles per half period of each note
  localparam logic [HALF_PERIOD_W-1:0] NOTE_HALF_PERIOD [8] = '{
    16'd47801,
    16'd42589,
    16'd37936,
    16'd35816,
    16'd31928,
    16'd28409,
    16'd25329,
    16'd23900
  };

  localparam int SAMPLE_W = 8;

  // Signed full-scale levels of the square wave
  localparam logic signed [SAMPLE_W-1:0] SAMPLE_HIGH = 8'sh7F;
  localparam logic signed [SAMPLE_W-1:0] SAMPLE_LOW  = 8'sh80;

  // ========================================
  // Speed and display
  // ========================================

  localparam int PERIOD_W = 16;
  localparam int DIGITS   = 6;
  localparam int SEG_W    = 7;

  // Active low with bit 0 as segment a and bit 6 as segment g
  localparam logic [SEG_W-1:0] SEG_PATTERN [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage

//--- hdl/input_sync.sv
`timescale 1ns/1ps

module input_sync #(
  parameter type T = logic
) (
  input  logic CLK_50M,
  input  logic rst_n,
  input  T     async_in,
  output T     sync_out
);

  T stage1;
  T stage2;

  // Two flops per bit against metastability
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      stage1 <= '0;
      stage2 <= '0;
    end
    else
    begin
      stage1 <= async_in;
      stage2 <= stage1;
    end
  end

  assign sync_out = stage2;

endmodule

//--- hdl/tone_generator.sv
`timescale 1ns/1ps

module tone_generator
  import organ_pkg::*;
(
  input  logic                       CLK_50M,
  input  logic                       rst_n,
  input  logic                       enable,
  input  note_t                      note,
  output logic signed [SAMPLE_W-1:0] audio_sample
);

  logic [HALF_PERIOD_W-1:0] half_period;
  logic [HALF_PERIOD_W-1:0] count;
  logic                     tone_high;
  note_t                    prev_note;
  logic                     restart;

  assign half_period = NOTE_HALF_PERIOD[note];

  // New note or tone off starts a fresh low half period
  assign restart = !enable || (note != prev_note);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      count     <= '0;
      tone_high <= 1'b0;
      prev_note <= '0;
    end
    else
    begin
      prev_note <= note;
      if (restart)
      begin
        count     <= half_period - 1'b1;
        tone_high <= 1'b0;
      end
      else if (count == '0)
      begin
        // Reload with H-1 so the level holds exactly H cycles
        count     <= half_period - 1'b1;
        tone_high <= ~tone_high;
      end
      else
      begin
        count <= count - 1'b1;
      end
    end
  end

  assign audio_sample = tone_high ? SAMPLE_HIGH : SAMPLE_LOW;

  // ========================================
  // Checks
  // ========================================

  // A disabled tone is silent on the next cycle
  a_disable_low: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    !enable |=> (audio_sample == SAMPLE_LOW)
  );

endmodule

//--- hdl/key_repeat.sv
`timescale 1ns/1ps

module key_repeat
  import organ_pkg::*;
#(
  parameter int TICK_DIV     = 50000,
  parameter int REPEAT_TICKS = 100
) (
  input  logic CLK_50M,
  input  logic rst_n,
  input  logic up_held,
  input  logic down_held,
  output logic up_step,
  output logic down_step
);

  localparam int TICK_W = (TICK_DIV > 2) ? $clog2(TICK_DIV) : 1;

  logic [TICK_W-1:0]   tick_cnt;
  logic                tick;
  logic [PERIOD_W-1:0] window;
  logic                window_end;

  // ========================================
  // Millisecond tick
  // ========================================

  assign tick = (tick_cnt == TICK_W'(TICK_DIV - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tick_cnt <= '0;
    end
    else if (tick)
    begin
      tick_cnt <= '0;
    end
    else
    begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // ========================================
  // Repeat window and step pulses
  // ========================================

  assign window_end = (window == PERIOD_W'(REPEAT_TICKS));

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      window    <= '0;
      up_step   <= 1'b0;
      down_step <= 1'b0;
    end
    else
    begin
      // Steps last one cycle unless the window closes on this tick
      up_step   <= 1'b0;
      down_step <= 1'b0;
      if (tick)
      begin
        if (window_end)
        begin
          window    <= '0;
          up_step   <= up_held;
          down_step <= down_held;
        end
        else
        begin
          window <= window + 1'b1;
        end
      end
    end
  end

  // ========================================
  // Checks
  // ========================================

  a_up_one_cycle: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    up_step |=> !up_step
  );

  a_down_one_cycle: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    down_step |=> !down_step
  );

endmodule

//--- hdl/speed_register.sv
`timescale 1ns/1ps

module speed_register
  import organ_pkg::*;
#(
  parameter int SPEED_STEP     = 100,
  parameter int DEFAULT_PERIOD = 12499
) (
  input  logic                CLK_50M,
  input  logic                rst_n,
  input  logic                up_step,
  input  logic                down_step,
  input  logic                clear,
  output logic [PERIOD_W-1:0] sample_period
);

  localparam logic [PERIOD_W-1:0] STEP_VAL    = PERIOD_W'(SPEED_STEP);
  localparam logic [PERIOD_W-1:0] DEFAULT_VAL = PERIOD_W'(DEFAULT_PERIOD);

  logic signed [PERIOD_W-1:0] offset;

  // Signed offset that wraps modulo 2^16
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      offset <= '0;
    end
    else if (clear)
    begin
      offset <= '0;
    end
    else if (up_step && !down_step)
    begin
      offset <= offset + STEP_VAL;
    end
    else if (down_step && !up_step)
    begin
      offset <= offset - STEP_VAL;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      sample_period <= DEFAULT_VAL;
    end
    else
    begin
      sample_period <= DEFAULT_VAL + offset;
    end
  end

endmodule

//--- hdl/hex_display.sv
`timescale 1ns/1ps

module hex_display
  import organ_pkg::*;
#(
  parameter int DISPLAY_DIV = 25000000
) (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic [DIGITS*4-1:0]   value,
  output logic [SEG_W-1:0]      hex0,
  output logic [SEG_W-1:0]      hex1,
  output logic [SEG_W-1:0]      hex2,
  output logic [SEG_W-1:0]      hex3,
  output logic [SEG_W-1:0]      hex4,
  output logic [SEG_W-1:0]      hex5
);

  localparam int DIV_W = (DISPLAY_DIV > 2) ? $clog2(DISPLAY_DIV) : 1;

  logic [DIV_W-1:0]    refresh_cnt;
  logic                refresh;
  logic [DIGITS*4-1:0] shown;
  logic [SEG_W-1:0]    digit_seg [DIGITS];

  assign refresh = (refresh_cnt == DIV_W'(DISPLAY_DIV - 1));

  // Slow refresh keeps the digits readable
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      refresh_cnt <= '0;
      shown       <= '0;
    end
    else if (refresh)
    begin
      refresh_cnt <= '0;
      shown       <= value;
    end
    else
    begin
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  // Digit 0 is the lowest nibble
  for (genvar d = 0; d < DIGITS; d++)
  begin : g_digit
    assign digit_seg[d] = SEG_PATTERN[shown[d*4 +: 4]];
  end

  assign hex0 = digit_seg[0];
  assign hex1 = digit_seg[1];
  assign hex2 = digit_seg[2];
  assign hex3 = digit_seg[3];
  assign hex4 = digit_seg[4];
  assign hex5 = digit_seg[5];

endmodule

//--- hdl/organ_top.sv
`timescale 1ns/1ps

module organ_top
  import organ_pkg::*;
#(
  parameter int TICK_DIV       = 50000,
  parameter int REPEAT_TICKS   = 100,
  parameter int SPEED_STEP     = 100,
  parameter int DEFAULT_PERIOD = 12499,
  parameter int DISPLAY_DIV    = 25000000
) (
  input  logic                       CLK_50M,
  input  logic                       rst_n,
  input  logic [2:0]                 key_n,
  input  logic [3:0]                 sw,
  output logic signed [SAMPLE_W-1:0] audio_sample,
  output logic [PERIOD_W-1:0]        sample_period,
  output logic [SEG_W-1:0]           hex0,
  output logic [SEG_W-1:0]           hex1,
  output logic [SEG_W-1:0]           hex2,
  output logic [SEG_W-1:0]           hex3,
  output logic [SEG_W-1:0]           hex4,
  output logic [SEG_W-1:0]           hex5
);

  logic [2:0] keys;
  logic [3:0] sw_sync;
  logic       up_step;
  logic       down_step;

  // ========================================
  // Input synchronizers
  // ========================================

  // Keys are active low on the board
  input_sync #(.T(logic [2:0])) key_sync (
    .CLK_50M  (CLK_50M),
    .rst_n    (rst_n),
    .async_in (~key_n),
    .sync_out (keys)
  );

  input_sync #(.T(logic [3:0])) switch_sync (
    .CLK_50M  (CLK_50M),
    .rst_n    (rst_n),
    .async_in (sw),
    .sync_out (sw_sync)
  );

  // ========================================
  // Tone path
  // ========================================

  tone_generator tone0 (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .enable       (sw_sync[0]),
    .note         (note_t'(sw_sync[3:1])),
    .audio_sample (audio_sample)
  );

  // ========================================
  // Speed control and readout
  // ========================================

  key_repeat #(
    .TICK_DIV     (TICK_DIV),
    .REPEAT_TICKS (REPEAT_TICKS)
  ) repeat0 (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .up_held   (keys[0]),
    .down_held (keys[1]),
    .up_step   (up_step),
    .down_step (down_step)
  );

  speed_register #(
    .SPEED_STEP     (SPEED_STEP),
    .DEFAULT_PERIOD (DEFAULT_PERIOD)
  ) speed0 (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .up_step       (up_step),
    .down_step     (down_step),
    .clear         (keys[2]),
    .sample_period (sample_period)
  );

  hex_display #(
    .DISPLAY_DIV (DISPLAY_DIV)
  ) display0 (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .value   ({{(DIGITS*4-PERIOD_W){1'b0}}, sample_period}),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

//--- test/organ_tb.sv
`timescale 1ns/1ps

module organ_tb;

  localparam int TICK_DIV       = 4;
  localparam int REPEAT_TICKS   = 3;
  localparam int SPEED_STEP     = 100;
  localparam int DEFAULT_PERIOD = 12499;
  localparam int DISPLAY_DIV    = 64;

  // Note half periods and hex segment patterns
  localparam int HALF [8] = '{47801, 42589, 37936, 35816, 31928, 28409, 25329, 23900};
  localparam logic [6:0] SEG [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  // ========================================
  // Speed key table
  // ========================================

  localparam int ROWS = 5;
  string      row_name  [ROWS] = '{"up_hold", "up_again", "down_hold", "both_held", "clear_key"};
  logic [3:0] row_sw    [ROWS] = '{4'b0000, 4'b0101, 4'b0000, 4'b1011, 4'b0000};
  logic [2:0] row_keys  [ROWS] = '{3'b110, 3'b110, 3'b101, 3'b100, 3'b011};
  int         row_hold  [ROWS] = '{12, 8, 8, 12, 4};
  int         row_delta [ROWS] = '{SPEED_STEP, SPEED_STEP, -SPEED_STEP, 0, 0};

  logic        CLK_50M = 1'b0;
  logic        rst_n;
  logic [2:0]  key_n;
  logic [3:0]  sw;
  logic [7:0]  audio_sample;
  logic [15:0] sample_period;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [6:0]  hex4;
  logic [6:0]  hex5;

  logic [31:0] lfsr_state;
  int          mismatches;
  int          timeouts;
  int          order [8];
  int          model_period;

  organ_top #(
    .TICK_DIV       (TICK_DIV),
    .REPEAT_TICKS   (REPEAT_TICKS),
    .SPEED_STEP     (SPEED_STEP),
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .DISPLAY_DIV    (DISPLAY_DIV)
  ) dut0 (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .key_n         (key_n),
    .sw            (sw),
    .audio_sample  (audio_sample),
    .sample_period (sample_period),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

  always #10 CLK_50M = ~CLK_50M;

  // Fibonacci LFSR with taps at bits 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual)
    else
    begin
      mismatches++;
      $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_display(input string name, input logic [23:0] value);
    logic [6:0] got [6];
    got = '{hex0, hex1, hex2, hex3, hex4, hex5};
    for (int d = 0; d < 6; d++)
      check_value($sformatf("%s hex%0d", name, d), int'(SEG[value[d*4 +: 4]]), int'(got[d]));
  endtask

  // Waits for the next tone edge and counts the cycles to it
  task automatic wait_flip(input string name, input int limit, output int cycles);
    logic [7:0] start;
    start  = audio_sample;
    cycles = 0;
    while (audio_sample == start && cycles < limit)
    begin
      @(negedge CLK_50M);
      cycles++;
      assert (audio_sample == 8'h7F || audio_sample == 8'h80)
      else
      begin
        mismatches++;
        $display("mismatch %s level: expected 7f or 80, actual %0h", name, audio_sample);
      end
    end
    assert (audio_sample != start)
    else
    begin
      timeouts++;
      $display("timeout in %s: the tone did not change within %0d cycles", name, limit);
    end
  endtask

  // ========================================
  // Speed row
  // ========================================

  task automatic run_row(input int r);
    int hold;
    int start;
    int prev;
    int changes;
    int cycles;
    int expected;
    int min_steps;
    hold    = row_hold[r] + take_bits(2);
    start   = model_period;
    prev    = start;
    changes = 0;
    sw      = row_sw[r];
    key_n   = row_keys[r];
    if (!row_keys[r][2])
    begin
      cycles = 0;
      while (int'(sample_period) != DEFAULT_PERIOD && cycles < 40)
      begin
        @(negedge CLK_50M);
        cycles++;
      end
      assert (int'(sample_period) == DEFAULT_PERIOD)
      else
      begin
        timeouts++;
        $display("timeout in %s: the period did not return to its default", row_name[r]);
      end
      repeat (hold * TICK_DIV) @(negedge CLK_50M);
      key_n = 3'b111;
      repeat (8) @(negedge CLK_50M);
      expected = DEFAULT_PERIOD;
    end
    else
    begin
      // Eight extra cycles let a step in flight land after release
      for (cycles = 0; cycles < hold * TICK_DIV + 8; cycles++)
      begin
        if (cycles == hold * TICK_DIV)
          key_n = 3'b111;
        @(negedge CLK_50M);
        if (int'(sample_period) != prev)
        begin
          changes++;
          check_value({row_name[r], " step"}, row_delta[r] & 16'hFFFF,
                      (int'(sample_period) - prev) & 16'hFFFF);
          prev = int'(sample_period);
        end
      end
      expected = (start + changes * row_delta[r]) & 16'hFFFF;
      if (row_delta[r] == 0)
      begin
        check_value({row_name[r], " changes"}, 0, changes);
      end
      else
      begin
        // One step per repeat window while the key is held
        min_steps = hold / (REPEAT_TICKS + 1);
        assert (changes >= min_steps && changes <= min_steps + 1)
        else
        begin
          mismatches++;
          $display("mismatch %s step count: expected %0d to %0d, actual %0d",
                   row_name[r], min_steps, min_steps + 1, changes);
        end
      end
    end
    check_value({row_name[r], " final"}, expected, int'(sample_period));
    repeat (2 * DISPLAY_DIV + 4) @(negedge CLK_50M);
    check_display(row_name[r], 24'(expected));
    model_period = expected;
  endtask

  initial
  begin
    int n;
    int tmp;
    int c;
    int bad;
    lfsr_state   = 32'h6b67_516c;
    mismatches   = 0;
    timeouts     = 0;
    model_period = DEFAULT_PERIOD;
    rst_n        = 1'b0;
    key_n        = 3'b111;
    sw           = 4'b0000;
    repeat (3) @(negedge CLK_50M);
    rst_n = 1'b1;
    @(negedge CLK_50M);
    check_value("reset sample", 8'h80, int'(audio_sample));
    check_value("reset period", DEFAULT_PERIOD, int'(sample_period));
    check_display("reset blank", 24'h000000);
    repeat (DISPLAY_DIV + 2) @(negedge CLK_50M);
    check_display("reset refresh", 24'h0030D3);

    // Notes in shuffled order
    for (int i = 0; i < 8; i++)
      order[i] = i;
    for (int i = 7; i > 0; i--)
    begin
      n        = take_bits(3) % (i + 1);
      tmp      = order[i];
      order[i] = order[n];
      order[n] = tmp;
    end
    for (int i = 0; i < 8; i++)
    begin
      n  = order[i];
      sw = {n[2:0], 1'b1};
      repeat (4) @(negedge CLK_50M);
      check_value($sformatf("note%0d restart", n), 8'h80, int'(audio_sample));
      wait_flip($sformatf("note%0d first", n), HALF[n] + 8, c);
      wait_flip($sformatf("note%0d high", n), HALF[n] + 8, c);
      check_value($sformatf("note%0d high half", n), HALF[n], c);
      wait_flip($sformatf("note%0d low", n), HALF[n] + 8, c);
      check_value($sformatf("note%0d low half", n), HALF[n], c);
    end

    // Tone off for one full period of the last note
    sw  = {n[2:0], 1'b0};
    bad = 0;
    repeat (4) @(negedge CLK_50M);
    for (c = 0; c < 2 * HALF[n]; c++)
    begin
      @(negedge CLK_50M);
      if (audio_sample != 8'h80)
        bad++;
    end
    check_value("tone_off high cycles", 0, bad);

    for (int r = 0; r < ROWS; r++)
      run_row(r);

    $display("Error counts: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches + timeouts == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

//--- project.f
hdl/organ_pkg.sv
hdl/input_sync.sv
hdl/tone_generator.sv
hdl/key_repeat.sv
hdl/speed_register.sv
hdl/hex_display.sv
hdl/organ_top.sv
test/organ_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the organ testbench with Verilator
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module organ_tb -f project.f -o organ_sim \
  && ./obj_dir/organ_sim > sim.log 2>&1
grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
